// File: Bender.yml
package:
  name: csr_file

sources:
  # RTL in compile order, package first
  - csr_pkg.sv
  - csr_counters.sv
  - csr_timer.sv
  - csr_setup_regs.sv
  - csr_trap_ctrl.sv
  - csr_read_mux.sv
  - csr_file.sv
  # Testbench
  - target: test
    files:
      - tb_csr_file.sv

// File: build.f
csr_pkg.sv
csr_counters.sv
csr_timer.sv
csr_setup_regs.sv
csr_trap_ctrl.sv
csr_read_mux.sv
csr_file.sv
tb_csr_file.sv

// File: csr_counters.sv
`timescale 1ns/1ps

module csr_counters
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  csr_access_t     csr_access,
    input  csr_data_t       wdata,
    input  logic            instr_retired,
    // Index 0 is the low half, index 1 the high half
    output csr_data_t [1:0] mcycle,
    output csr_data_t [1:0] minstret
);

    // Counter 0 is mcycle, counter 1 is minstret
    localparam csr_addr_t LO_ADDR [2] = '{CSR_MCYCLE, CSR_MINSTRET};
    localparam csr_addr_t HI_ADDR [2] = '{CSR_MCYCLEH, CSR_MINSTRETH};

    csr_data_t  operand;
    logic [1:0] inc;

    assign operand = csr_operand(csr_access, wdata);

    // mcycle counts every clock, minstret only on retire
    assign inc = {instr_retired, 1'b1};

    // ====================
    // One 64-bit counter per slot
    // ====================
    for (genvar i = 0; i < 2; i++) begin : g_cnt
        csr_data_t [1:0] cnt_q;
        csr_data_t [1:0] cnt_d;
        logic            carry;

        always_comb begin
            // Low half with carry out into high half
            {carry, cnt_d[0]} = {1'b0, cnt_q[0]} + 33'(inc[i]);
            cnt_d[1]          = cnt_q[1] + 32'(carry);
            // Software write replaces the half it hits
            if (csr_write_hit(csr_access, LO_ADDR[i])) begin
                cnt_d[0] = csr_write_value(csr_access.op, cnt_q[0], operand);
            end
            if (csr_write_hit(csr_access, HI_ADDR[i])) begin
                cnt_d[1] = csr_write_value(csr_access.op, cnt_q[1], operand);
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_d;
            end
        end
    end

    assign mcycle   = g_cnt[0].cnt_q;
    assign minstret = g_cnt[1].cnt_q;

    // Idle minstret low holds across the edge
    a_minstret_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_retired && !csr_write_hit(csr_access, CSR_MINSTRET)
        |=> $stable(minstret[0]));

endmodule

// File: csr_file.sv
`timescale 1ns/1ps

module csr_file
    import csr_pkg::*;
#(
    parameter csr_data_t MTVEC_RESET    = '0,
    parameter csr_data_t MTIMECMP_RESET = '1
) (
    input  logic         clk,
    input  logic         rst_n,
    input  csr_access_t  csr_access,
    input  csr_data_t    rs1_data,
    input  logic         instr_retired,
    input  trap_event_t  trap_event,
    output csr_data_t    read_data,
    output pc_redirect_t pc_redirect,
    output logic         timer_irq
);

    // ====================
    // Register values
    // ====================
    csr_data_t [1:0] mcycle;
    csr_data_t [1:0] minstret;
    csr_data_t       mtime;
    csr_data_t       mtimecmp;
    csr_data_t       mip;
    logic            mtime_reached;
    csr_data_t       mtvec;
    csr_data_t       mie;
    csr_data_t       mscratch;
    csr_data_t       mstatus;
    csr_data_t       mepc;
    csr_data_t       mcause;
    csr_data_t       mtval;

    // Cycle and instret counters
    csr_counters u_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_access    (csr_access),
        .wdata         (rs1_data),
        .instr_retired (instr_retired),
        .mcycle        (mcycle),
        .minstret      (minstret)
    );

    // mtime, mtimecmp and mip
    csr_timer #(
        .MTIMECMP_RESET (MTIMECMP_RESET)
    ) u_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_access    (csr_access),
        .wdata         (rs1_data),
        .timer_irq     (timer_irq),
        .mtime         (mtime),
        .mtimecmp      (mtimecmp),
        .mip           (mip),
        .mtime_reached (mtime_reached)
    );

    csr_setup_regs #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_setup_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_access (csr_access),
        .wdata      (rs1_data),
        .mtvec      (mtvec),
        .mie        (mie),
        .mscratch   (mscratch)
    );

    // Trap entry, mret and interrupt request
    csr_trap_ctrl u_trap_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_access    (csr_access),
        .wdata         (rs1_data),
        .trap_event    (trap_event),
        .mtime_reached (mtime_reached),
        .mie           (mie),
        .mtvec         (mtvec),
        .mstatus       (mstatus),
        .mepc          (mepc),
        .mcause        (mcause),
        .mtval         (mtval),
        .pc_redirect   (pc_redirect),
        .timer_irq     (timer_irq)
    );

    csr_read_mux u_read_mux (
        .csr_access (csr_access),
        .mstatus    (mstatus),
        .mie        (mie),
        .mtvec      (mtvec),
        .mscratch   (mscratch),
        .mepc       (mepc),
        .mcause     (mcause),
        .mtval      (mtval),
        .mip        (mip),
        .mcycle     (mcycle),
        .minstret   (minstret),
        .mtime      (mtime),
        .mtimecmp   (mtimecmp),
        .read_data  (read_data)
    );

endmodule

// File: csr_pkg.sv
package csr_pkg;

    // ====================
    // Widths
    // ====================
    typedef logic [31:0] csr_data_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [1:0]  csr_op_t;

    // Access operations, zero is no-op
    localparam csr_op_t CSR_OP_WRITE = 2'd1;
    localparam csr_op_t CSR_OP_SET   = 2'd2;
    localparam csr_op_t CSR_OP_CLEAR = 2'd3;

    // ====================
    // CSR addresses
    // ====================
    localparam csr_addr_t CSR_MSTATUS         = 12'h300;
    localparam csr_addr_t CSR_MIE             = 12'h304;
    localparam csr_addr_t CSR_MTVEC           = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH        = 12'h340;
    localparam csr_addr_t CSR_MEPC            = 12'h341;
    localparam csr_addr_t CSR_MCAUSE          = 12'h342;
    localparam csr_addr_t CSR_MTVAL           = 12'h343;
    localparam csr_addr_t CSR_MIP             = 12'h344;
    localparam csr_addr_t CSR_MCYCLE          = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET        = 12'hB02;
    localparam csr_addr_t CSR_MCYCLEH         = 12'hB80;
    localparam csr_addr_t CSR_MINSTRETH       = 12'hB82;
    // User read-only aliases
    localparam csr_addr_t CSR_CYCLE           = 12'hC00;
    localparam csr_addr_t CSR_INSTRET         = 12'hC02;
    localparam csr_addr_t CSR_CYCLEH          = 12'hC80;
    localparam csr_addr_t CSR_INSTRETH        = 12'hC82;
    // Custom machine RW space
    localparam csr_addr_t CSR_CUSTOM_MTIME    = 12'hBC1;
    localparam csr_addr_t CSR_CUSTOM_MTIMECMP = 12'hBC2;

    // Trap causes
    localparam csr_data_t CAUSE_TIMER_IRQ     = 32'h8000_0007;
    localparam csr_data_t CAUSE_ILLEGAL_INSTR = 32'd2;
    localparam csr_data_t CAUSE_BREAKPOINT    = 32'd3;
    localparam csr_data_t CAUSE_MISALIGNED    = 32'd4;
    localparam csr_data_t CAUSE_ILLEGAL_CSR   = 32'd11;

    // Bit positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIE_MTIE_BIT     = 7;
    localparam int MIP_MTIP_BIT     = 7;

    // ====================
    // Port structs
    // ====================
    typedef struct packed {
        logic      wren;
        logic      rden;
        csr_op_t   op;
        csr_addr_t addr;
        logic      imm_sel;
        csr_data_t imm;
    } csr_access_t;

    typedef struct packed {
        logic      timer_taken;
        logic      illegal_instr;
        logic      misaligned;
        logic      illegal_csr;
        logic      breakpoint;
        logic      mret;
        csr_data_t pc;
        csr_data_t mtval;
    } trap_event_t;

    typedef struct packed {
        logic      trap_en;
        csr_data_t trap_addr;
        logic      return_en;
        csr_data_t return_addr;
    } pc_redirect_t;

    // Immediate or register operand
    function automatic csr_data_t csr_operand(csr_access_t access, csr_data_t wdata);
        return access.imm_sel ? access.imm : wdata;
    endfunction

    // Software write aimed at one address
    function automatic logic csr_write_hit(csr_access_t access, csr_addr_t addr);
        return access.wren && (access.addr == addr);
    endfunction

    function automatic csr_data_t csr_write_value(csr_op_t op, csr_data_t old_value,
                                                  csr_data_t operand);
        csr_data_t result;
        case (op)
            CSR_OP_WRITE: result = operand;
            CSR_OP_SET:   result = old_value | operand;
            CSR_OP_CLEAR: result = old_value & ~operand;
            default:      result = old_value;
        endcase
        return result;
    endfunction

endpackage

// File: csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux
    import csr_pkg::*;
(
    input  csr_access_t     csr_access,
    input  csr_data_t       mstatus,
    input  csr_data_t       mie,
    input  csr_data_t       mtvec,
    input  csr_data_t       mscratch,
    input  csr_data_t       mepc,
    input  csr_data_t       mcause,
    input  csr_data_t       mtval,
    input  csr_data_t       mip,
    input  csr_data_t [1:0] mcycle,
    input  csr_data_t [1:0] minstret,
    input  csr_data_t       mtime,
    input  csr_data_t       mtimecmp,
    output csr_data_t       read_data
);

    // ====================
    // Read decode
    // ====================
    // Unmapped addresses, ID registers included, read zero
    always_comb begin
        read_data = '0;
        if (csr_access.rden) begin
            unique case (csr_access.addr)
                CSR_MSTATUS:         read_data = mstatus;
                CSR_MIE:             read_data = mie;
                CSR_MTVEC:           read_data = mtvec;
                CSR_MSCRATCH:        read_data = mscratch;
                CSR_MEPC:            read_data = mepc;
                CSR_MCAUSE:          read_data = mcause;
                CSR_MTVAL:           read_data = mtval;
                CSR_MIP:             read_data = mip;
                // Machine counters
                CSR_MCYCLE:          read_data = mcycle[0];
                CSR_MCYCLEH:         read_data = mcycle[1];
                CSR_MINSTRET:        read_data = minstret[0];
                CSR_MINSTRETH:       read_data = minstret[1];
                // User aliases of the same counters
                CSR_CYCLE:           read_data = mcycle[0];
                CSR_CYCLEH:          read_data = mcycle[1];
                CSR_INSTRET:         read_data = minstret[0];
                CSR_INSTRETH:        read_data = minstret[1];
                // Custom timer pair
                CSR_CUSTOM_MTIME:    read_data = mtime;
                CSR_CUSTOM_MTIMECMP: read_data = mtimecmp;
                default:             read_data = '0;
            endcase
        end
    end

    // Idle port reads zero
    always_comb begin
        a_idle_zero: assert final (csr_access.rden || (read_data == '0));
    end

endmodule

// File: csr_setup_regs.sv
`timescale 1ns/1ps

module csr_setup_regs
    import csr_pkg::*;
#(
    parameter csr_data_t MTVEC_RESET = '0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  csr_access_t csr_access,
    input  csr_data_t   wdata,
    output csr_data_t   mtvec,
    output csr_data_t   mie,
    output csr_data_t   mscratch
);

    // Slot order: mtvec, mie, mscratch
    localparam int        NUM_REGS           = 3;
    localparam csr_addr_t REG_ADDR [NUM_REGS] = '{CSR_MTVEC, CSR_MIE, CSR_MSCRATCH};
    localparam csr_data_t REG_RST  [NUM_REGS] = '{MTVEC_RESET, '0, '0};

    csr_data_t operand;

    assign operand = csr_operand(csr_access, wdata);

    // ====================
    // Plain software registers
    // ====================
    for (genvar i = 0; i < NUM_REGS; i++) begin : g_reg
        csr_data_t val_q;
        csr_data_t val_d;

        // No hardware source, only the CSR port
        always_comb begin
            val_d = val_q;
            if (csr_write_hit(csr_access, REG_ADDR[i])) begin
                val_d = csr_write_value(csr_access.op, val_q, operand);
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                val_q <= REG_RST[i];
            end else begin
                val_q <= val_d;
            end
        end
    end

    assign mtvec    = g_reg[0].val_q;
    assign mie      = g_reg[1].val_q;
    assign mscratch = g_reg[2].val_q;

endmodule

// File: csr_timer.sv
`timescale 1ns/1ps

module csr_timer
    import csr_pkg::*;
#(
    parameter csr_data_t MTIMECMP_RESET = '1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  csr_access_t csr_access,
    input  csr_data_t   wdata,
    input  logic        timer_irq,
    output csr_data_t   mtime,
    output csr_data_t   mtimecmp,
    output csr_data_t   mip,
    output logic        mtime_reached
);

    csr_data_t operand;
    csr_data_t mtimecmp_d;
    csr_data_t mip_d;

    assign operand = csr_operand(csr_access, wdata);

    // Compare point for the timer interrupt
    assign mtime_reached = (mtime >= mtimecmp);

    always_comb begin
        mtimecmp_d = mtimecmp;
        mip_d      = mip;
        if (csr_write_hit(csr_access, CSR_CUSTOM_MTIMECMP)) begin
            mtimecmp_d = csr_write_value(csr_access.op, mtimecmp, operand);
        end
        // Sticky pending bit from the request
        if (timer_irq) begin
            mip_d[MIP_MTIP_BIT] = 1'b1;
        end
        // software write overrides the hw set
        if (csr_write_hit(csr_access, CSR_MIP)) begin
            mip_d = csr_write_value(csr_access.op, mip, operand);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime    <= '0;
            mtimecmp <= MTIMECMP_RESET;
            mip      <= '0;
        end else begin
            // Free running, no write path
            mtime    <= mtime + 32'd1;
            mtimecmp <= mtimecmp_d;
            mip      <= mip_d;
        end
    end

endmodule

// File: csr_trap_ctrl.sv
`timescale 1ns/1ps

module csr_trap_ctrl
    import csr_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  csr_access_t  csr_access,
    input  csr_data_t    wdata,
    input  trap_event_t  trap_event,
    input  logic         mtime_reached,
    input  csr_data_t    mie,
    input  csr_data_t    mtvec,
    output csr_data_t    mstatus,
    output csr_data_t    mepc,
    output csr_data_t    mcause,
    output csr_data_t    mtval,
    output pc_redirect_t pc_redirect,
    output logic         timer_irq
);

    csr_data_t operand;
    logic      exception;
    logic      any_trap;
    csr_data_t mstatus_d;
    csr_data_t mepc_d;
    csr_data_t mcause_d;
    csr_data_t mtval_d;

    assign operand = csr_operand(csr_access, wdata);

    // Synchronous exceptions, all carry an mtval
    assign exception = trap_event.illegal_instr | trap_event.misaligned |
                       trap_event.illegal_csr   | trap_event.breakpoint;
    assign any_trap  = exception | trap_event.timer_taken;

    // ====================
    // Timer interrupt request
    // ====================
    // Reached, globally enabled, and MTIE set
    assign timer_irq = mtime_reached && mstatus[MSTATUS_MIE_BIT] && mie[MIE_MTIE_BIT];

    // ====================
    // Trap entry and return
    // ====================
    always_comb begin
        mstatus_d = mstatus;
        mepc_d    = mepc;
        mcause_d  = mcause;
        mtval_d   = mtval;

        if (any_trap) begin
            mepc_d = trap_event.pc;
        end
        // Timer alone leaves mtval untouched
        if (exception) begin
            mtval_d = trap_event.mtval;
        end

        // Fixed priority, breakpoint first
        if (trap_event.breakpoint) begin
            mcause_d = CAUSE_BREAKPOINT;
        end else if (trap_event.illegal_csr) begin
            mcause_d = CAUSE_ILLEGAL_CSR;
        end else if (trap_event.misaligned) begin
            mcause_d = CAUSE_MISALIGNED;
        end else if (trap_event.illegal_instr) begin
            mcause_d = CAUSE_ILLEGAL_INSTR;
        end else if (trap_event.timer_taken) begin
            mcause_d = CAUSE_TIMER_IRQ;
        end

        // Interrupt entry masks further interrupts
        if (trap_event.timer_taken) begin
            mstatus_d[MSTATUS_MPIE_BIT] = mstatus[MSTATUS_MIE_BIT];
            mstatus_d[MSTATUS_MIE_BIT]  = 1'b0;
        end
        // mret brings back the prior enable
        if (trap_event.mret) begin
            mstatus_d[MSTATUS_MIE_BIT] = mstatus[MSTATUS_MPIE_BIT];
        end

        // Software writes last, so they win
        if (csr_write_hit(csr_access, CSR_MSTATUS)) begin
            mstatus_d = csr_write_value(csr_access.op, mstatus, operand);
        end
        if (csr_write_hit(csr_access, CSR_MEPC)) begin
            mepc_d = csr_write_value(csr_access.op, mepc, operand);
        end
        if (csr_write_hit(csr_access, CSR_MCAUSE)) begin
            mcause_d = csr_write_value(csr_access.op, mcause, operand);
        end
        if (csr_write_hit(csr_access, CSR_MTVAL)) begin
            mtval_d = csr_write_value(csr_access.op, mtval, operand);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus <= '0;
            mepc    <= '0;
            mcause  <= '0;
            mtval   <= '0;
        end else begin
            mstatus <= mstatus_d;
            mepc    <= mepc_d;
            mcause  <= mcause_d;
            mtval   <= mtval_d;
        end
    end

    // PC redirect, same cycle as the event
    assign pc_redirect.trap_en     = any_trap;
    assign pc_redirect.trap_addr   = mtvec;
    assign pc_redirect.return_en   = trap_event.mret;
    assign pc_redirect.return_addr = mepc;

    // Core never traps and returns in one cycle
    a_no_trap_and_return: assert property (@(posedge clk) disable iff (!rst_n)
        !(pc_redirect.trap_en && pc_redirect.return_en));

endmodule

// File: tb_csr_file.sv
`timescale 1ns/1ps

module tb_csr_file
    import csr_pkg::*;
();

    // ====================
    // Run setup
    // ====================
    localparam csr_data_t MTVEC_RESET    = 32'h0000_0100;
    localparam csr_data_t MTIMECMP_RESET = 32'hFFFF_FFFF;
    localparam int        REPS           = 4;
    localparam int        TIMER_DELTA    = 20;
    localparam int        RETIRE_CYCLES  = 32;
    // Rough cycle cost of each test
    localparam int RESET_CYCLES    = 10 + 4;
    localparam int SW_CYCLES       = 2 * 3 * 2 * REPS * 3;
    localparam int COUNTER_CYCLES  = 6 + REPS * 18 + RETIRE_CYCLES + 4;
    localparam int TRAP_CYCLES     = 2 * 5;
    localparam int TIMER_CYCLES    = 4 + 2 * TIMER_DELTA + 10;
    localparam int UNMAPPED_CYCLES = 8 + 4 + 2;
    localparam int MAX_CYCLES      = RESET_CYCLES + SW_CYCLES + COUNTER_CYCLES + TRAP_CYCLES
                                   + TIMER_CYCLES + UNMAPPED_CYCLES + 200;

    logic         clk;
    logic         rst_n;
    csr_access_t  acc;
    csr_data_t    rs1;
    logic         retired;
    trap_event_t  trap;
    csr_data_t    read_data;
    pc_redirect_t pc_redirect;
    logic         timer_irq;

    logic [31:0] lfsr_state;
    csr_data_t   mtvec_model;
    int          error_count  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cycle_count  = 0;

    csr_file #(
        .MTVEC_RESET    (MTVEC_RESET),
        .MTIMECMP_RESET (MTIMECMP_RESET)
    ) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_access    (acc),
        .rs1_data      (rs1),
        .instr_retired (retired),
        .trap_event    (trap),
        .read_data     (read_data),
        .pc_redirect   (pc_redirect),
        .timer_irq     (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Cycle budget for the whole run
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("Run stopped by timeout after %0d cycles", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Idle read port returns zero
    a_idle_read: assert property (@(posedge clk) disable iff (!rst_n)
        !acc.rden |-> read_data == '0)
        else begin
            $display("** Error @ %0t ns: read_data %h with rden low", $time, read_data);
            error_count++;
        end

    // ====================
    // Helpers
    // ====================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Reference rule for write, set and clear
    function automatic csr_data_t model_write(csr_op_t op, csr_data_t old_value,
                                              csr_data_t operand);
        if (op == 2'd1) return operand;
        if (op == 2'd2) return old_value | operand;
        if (op == 2'd3) return old_value & ~operand;
        return old_value;
    endfunction

    function automatic logic is_mapped(csr_addr_t addr);
        case (addr)
            12'h300, 12'h304, 12'h305, 12'h340, 12'h341, 12'h342, 12'h343, 12'h344,
            12'hB00, 12'hB02, 12'hB80, 12'hB82, 12'hC00, 12'hC02, 12'hC80, 12'hC82,
            12'hBC1, 12'hBC2: return 1'b1;
            default:          return 1'b0;
        endcase
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int n, output csr_data_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input csr_data_t got, input csr_data_t exp);
        assert (got === exp)
        else begin
            $display("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    // Read sampled mid-cycle
    task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
        acc.rden = 1'b1;
        acc.addr = addr;
        @(negedge clk);
        data = read_data;
        next_cycle();
        acc = '0;
    endtask

    task automatic csr_op(input csr_op_t op, input csr_addr_t addr, input logic imm_sel,
                          input csr_data_t imm, input csr_data_t value);
        acc.wren    = 1'b1;
        acc.op      = op;
        acc.addr    = addr;
        acc.imm_sel = imm_sel;
        acc.imm     = imm;
        rs1         = value;
        next_cycle();
        acc = '0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %-10s ok", name);
        end else begin
            tests_failed++;
            $display("test %-10s FAILED with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ====================
    // Tests
    // ====================
    task automatic test_reset();
        csr_data_t got;
        @(negedge clk);
        check_value("timer_irq after reset", timer_irq, 0);
        check_value("trap_en after reset", pc_redirect.trap_en, 0);
        check_value("return_en after reset", pc_redirect.return_en, 0);
        next_cycle();
        csr_read(CSR_MTVEC, got);
        check_value("mtvec reset", got, MTVEC_RESET);
        csr_read(CSR_CUSTOM_MTIMECMP, got);
        check_value("mtimecmp reset", got, MTIMECMP_RESET);
    endtask

    task automatic test_software();
        csr_addr_t regs  [2];
        csr_op_t   ops   [3];
        csr_data_t model [2];
        csr_data_t reg_val;
        csr_data_t imm;
        csr_data_t got;
        regs  = '{CSR_MSCRATCH, CSR_MTVEC};
        ops   = '{2'd1, 2'd2, 2'd3};
        model = '{32'h0, MTVEC_RESET};
        for (int r = 0; r < REPS; r++) begin
            foreach (regs[i]) begin
                foreach (ops[j]) begin
                    for (int sel = 0; sel < 2; sel++) begin
                        csr_read(regs[i], got);
                        check_value("value before op", got, model[i]);
                        // Unused operand carries junk
                        rand_bits(5, imm);
                        rand_bits(32, reg_val);
                        csr_op(ops[j], regs[i], sel[0], imm, reg_val);
                        model[i] = model_write(ops[j], model[i], sel ? imm : reg_val);
                        csr_read(regs[i], got);
                        check_value("value after op", got, model[i]);
                    end
                end
            end
        end
        mtvec_model = model[1];
    endtask

    task automatic test_counters();
        csr_data_t first;
        csr_data_t second;
        csr_data_t k;
        csr_data_t bit_val;
        int        retires;
        // Alias read one cycle after its machine counter
        csr_read(CSR_MCYCLE, first);
        csr_read(CSR_CYCLE, second);
        check_value("cycle alias", second, first + 1);
        csr_read(CSR_MCYCLEH, first);
        csr_read(CSR_CYCLEH, second);
        check_value("cycleh alias", second, first);
        csr_read(CSR_MINSTRET, first);
        csr_read(CSR_INSTRET, second);
        check_value("instret alias", second, first);
        for (int r = 0; r < REPS; r++) begin
            rand_bits(4, k);
            k++;
            csr_read(CSR_MCYCLE, first);
            repeat (k - 1) next_cycle();
            csr_read(CSR_MCYCLE, second);
            check_value("mcycle delta", second - first, k);
        end
        // Random retire pulses
        csr_read(CSR_MINSTRET, first);
        retires = 0;
        repeat (RETIRE_CYCLES) begin
            rand_bits(1, bit_val);
            retired = bit_val[0];
            retires += bit_val[0];
            next_cycle();
        end
        retired = 1'b0;
        csr_read(CSR_MINSTRET, second);
        check_value("minstret delta", second - first, retires);
        rand_bits(32, k);
        csr_op(2'd1, CSR_MCYCLE, 1'b0, '0, k);
        csr_read(CSR_MCYCLE, second);
        check_value("mcycle after write", second, k);
    endtask

    task automatic test_traps();
        csr_data_t pc;
        csr_data_t tval;
        csr_data_t got;
        // Second pass adds a breakpoint, which outranks illegal instruction
        for (int bp = 0; bp < 2; bp++) begin
            rand_bits(32, pc);
            rand_bits(32, tval);
            trap.illegal_instr = 1'b1;
            trap.breakpoint    = bp[0];
            trap.pc            = pc;
            trap.mtval         = tval;
            @(negedge clk);
            check_value("trap_en", pc_redirect.trap_en, 1);
            check_value("trap_addr", pc_redirect.trap_addr, mtvec_model);
            next_cycle();
            trap = '0;
            csr_read(CSR_MCAUSE, got);
            check_value("mcause", got, bp ? 32'd3 : 32'd2);
            csr_read(CSR_MEPC, got);
            check_value("mepc", got, pc);
            csr_read(CSR_MTVAL, got);
            check_value("mtval", got, tval);
        end
    endtask

    task automatic test_timer();
        csr_data_t start;
        csr_data_t pc;
        csr_data_t got;
        int        waited;
        csr_read(CSR_CUSTOM_MTIME, start);
        csr_op(2'd1, CSR_CUSTOM_MTIMECMP, 1'b0, '0, start + TIMER_DELTA);
        csr_op(2'd2, CSR_MIE, 1'b1, 32'h80, '0);
        csr_op(2'd2, CSR_MSTATUS, 1'b1, 32'h8, '0);
        // Watch mtime while waiting for the request
        acc.rden = 1'b1;
        acc.addr = CSR_CUSTOM_MTIME;
        waited   = 0;
        @(negedge clk);
        while (!timer_irq && waited < 2 * TIMER_DELTA) begin
            @(negedge clk);
            waited++;
        end
        if (!timer_irq) begin
            $display("timer_irq never rose within %0d cycles", 2 * TIMER_DELTA);
            error_count++;
        end else begin
            check_value("mtime at timer_irq", read_data, start + TIMER_DELTA);
        end
        next_cycle();
        acc = '0;
        csr_read(CSR_MIP, got);
        check_value("mip.MTIP", got[7], 1);
        // Take the interrupt
        rand_bits(32, pc);
        trap.timer_taken = 1'b1;
        trap.pc          = pc;
        @(negedge clk);
        check_value("trap_en on timer", pc_redirect.trap_en, 1);
        next_cycle();
        trap = '0;
        @(negedge clk);
        check_value("timer_irq after entry", timer_irq, 0);
        next_cycle();
        csr_read(CSR_MCAUSE, got);
        check_value("mcause timer", got, 32'h8000_0007);
        csr_read(CSR_MSTATUS, got);
        check_value("mstatus after entry", got, 32'h80);
        // Return from the handler
        trap.mret = 1'b1;
        @(negedge clk);
        check_value("return_en", pc_redirect.return_en, 1);
        check_value("return_addr", pc_redirect.return_addr, pc);
        check_value("trap_en on mret", pc_redirect.trap_en, 0);
        next_cycle();
        trap = '0;
        csr_read(CSR_MSTATUS, got);
        check_value("mstatus after mret", got, 32'h88);
        csr_op(2'd3, CSR_MIE, 1'b1, 32'h80, '0);
    endtask

    task automatic test_unmapped();
        csr_data_t raw;
        csr_data_t got;
        for (int i = 0; i < 8; i++) begin
            rand_bits(12, raw);
            while (is_mapped(raw[11:0])) begin
                rand_bits(12, raw);
            end
            csr_read(raw[11:0], got);
            check_value("unmapped read", got, '0);
        end
        // ID registers, mvendorid to mhartid
        for (int a = 'hF11; a <= 'hF14; a++) begin
            csr_read(csr_addr_t'(a), got);
            check_value("ID register read", got, '0);
        end
        acc.addr = CSR_MSCRATCH;
        @(negedge clk);
        check_value("read with rden low", read_data, '0);
        next_cycle();
        acc = '0;
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        int errors_before;
        acc         = '0;
        rs1         = '0;
        retired     = 1'b0;
        trap        = '0;
        rst_n       = 1'b0;
        lfsr_state  = 32'h70860773;
        mtvec_model = MTVEC_RESET;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        errors_before = error_count;
        test_reset();
        finish_test("reset", errors_before);
        errors_before = error_count;
        test_software();
        finish_test("software", errors_before);
        errors_before = error_count;
        test_counters();
        finish_test("counters", errors_before);
        errors_before = error_count;
        test_traps();
        finish_test("traps", errors_before);
        errors_before = error_count;
        test_timer();
        finish_test("timer", errors_before);
        errors_before = error_count;
        test_unmapped();
        finish_test("unmapped", errors_before);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
